//--- cache_types.sv
package cache_types;

    // ------------------------------------------------------------
    // geometry
    // ------------------------------------------------------------

    // address is offset, then index, then tag.
    localparam int offset_bits = 5;
    localparam int index_bits  = 4;
    localparam int tag_bits    = 32 - index_bits - offset_bits;

    localparam int num_sets  = 16;
    localparam int num_ways  = 4;
    localparam int line_bits = 256;
    localparam int mask_bits = 32;

    // ------------------------------------------------------------
    // datapath selects and control states
    // ------------------------------------------------------------

    // which way a data or dirty write goes to.
    typedef enum logic {
        hit_way = 1'b0,
        lru_way = 1'b1
    } way_sel_t;

    // cpu bytes under byte enable, or a whole line from memory.
    typedef enum logic {
        cpu_data = 1'b0,
        mem_data = 1'b1
    } data_src_t;

    // tag placed on the physical address.
    typedef enum logic {
        cpu_tag    = 1'b0,
        victim_tag = 1'b1
    } pmem_addr_src_t;

    typedef enum logic [1:0] {
        check     = 2'b00,
        writeback = 2'b01,
        fill      = 2'b10
    } cache_state_t;

endpackage : cache_types

//--- cache_ctrl_if.sv
`timescale 1ns/100ps

interface cache_ctrl_if;

    // status from the datapath.
    logic hit;
    logic victim_dirty;

    // load strobes, each writes at the edge ending its cycle.
    logic ld_valid;
    logic ld_tag;
    logic ld_data;
    logic ld_dirty;
    logic ld_plru;
    logic dirty_val;

    cache_types::way_sel_t       data_way_sel;
    cache_types::way_sel_t       dirty_way_sel;
    cache_types::data_src_t      data_src;
    cache_types::pmem_addr_src_t pmem_addr_src;

    modport control (
        input  hit, victim_dirty,
        output ld_valid, ld_tag, ld_data, ld_dirty, ld_plru, dirty_val,
        output data_way_sel, dirty_way_sel, data_src, pmem_addr_src
    );

    modport datapath (
        output hit, victim_dirty,
        input  ld_valid, ld_tag, ld_data, ld_dirty, ld_plru, dirty_val,
        input  data_way_sel, dirty_way_sel, data_src, pmem_addr_src
    );

endinterface : cache_ctrl_if

//--- cache_data_array.sv
`timescale 1ns/100ps

module cache_data_array (
    input  logic                               clk,
    input  logic                               we,
    input  logic [cache_types::mask_bits-1:0]  wmask,
    input  logic [cache_types::index_bits-1:0] index,
    input  logic [cache_types::line_bits-1:0]  din,
    output logic [cache_types::line_bits-1:0]  dout
);

    logic [cache_types::line_bits-1:0] lines [cache_types::num_sets];

    // byte lanes written only where enabled.
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < cache_types::mask_bits; b++) begin
                if (wmask[b]) begin
                    lines[index][8*b +: 8] <= din[8*b +: 8];
                end
            end
        end
    end

    assign dout = lines[index];

endmodule : cache_data_array

//--- cache_tag_array.sv
`timescale 1ns/100ps

module cache_tag_array (
    input  logic                               clk,
    input  logic                               we,
    input  logic [cache_types::index_bits-1:0] index,
    input  logic [cache_types::tag_bits-1:0]   din,
    output logic [cache_types::tag_bits-1:0]   dout
);

    logic [cache_types::tag_bits-1:0] tags [cache_types::num_sets];

    always_ff @(posedge clk) begin
        if (we) begin
            tags[index] <= din;
        end
    end

    // read is combinational.
    assign dout = tags[index];

endmodule : cache_tag_array

//--- cache_flag_array.sv
`timescale 1ns/100ps

module cache_flag_array (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               we,
    input  logic [cache_types::index_bits-1:0] index,
    input  logic                               din,
    output logic                               dout
);

    logic [cache_types::num_sets-1:0] flags;

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (we) begin
            flags[index] <= din;
        end
    end

    assign dout = flags[index];

endmodule : cache_flag_array

//--- cache_datapath.sv
`timescale 1ns/100ps

module cache_datapath (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [31:0]                        mem_address,
    input  logic [cache_types::mask_bits-1:0]  mem_byte_enable,
    input  logic [cache_types::line_bits-1:0]  mem_wdata,
    output logic [cache_types::line_bits-1:0]  mem_rdata,
    output logic [31:0]                        pmem_address,
    output logic [cache_types::line_bits-1:0]  pmem_wdata,
    input  logic [cache_types::line_bits-1:0]  pmem_rdata,
    cache_ctrl_if.datapath                     ctrl
);

    logic [cache_types::tag_bits-1:0]   addr_tag;
    logic [cache_types::index_bits-1:0] addr_index;

    assign addr_tag   = mem_address[31 -: cache_types::tag_bits];
    assign addr_index = mem_address[cache_types::offset_bits +: cache_types::index_bits];

    logic [cache_types::line_bits-1:0] way_data  [cache_types::num_ways];
    logic [cache_types::tag_bits-1:0]  way_tag   [cache_types::num_ways];
    logic                              way_valid [cache_types::num_ways];
    logic                              way_dirty [cache_types::num_ways];

    logic [1:0] hit_idx;
    logic [1:0] lru_idx;
    logic [1:0] data_idx;
    logic [1:0] dirty_idx;

    // ------------------------------------------------------------
    // hit detection
    // ------------------------------------------------------------

    always_comb begin
        ctrl.hit = 1'b0;
        hit_idx  = 2'd0;
        for (int w = 0; w < cache_types::num_ways; w++) begin
            if (way_valid[w] && way_tag[w] == addr_tag) begin
                ctrl.hit = 1'b1;
                hit_idx  = 2'(w);
            end
        end
    end

    assign ctrl.victim_dirty = way_valid[lru_idx] & way_dirty[lru_idx];

    assign data_idx  = (ctrl.data_way_sel == cache_types::lru_way) ? lru_idx : hit_idx;
    assign dirty_idx = (ctrl.dirty_way_sel == cache_types::lru_way) ? lru_idx : hit_idx;

    assign mem_rdata  = way_data[hit_idx];
    assign pmem_wdata = way_data[lru_idx];
    assign pmem_address = {
        (ctrl.pmem_addr_src == cache_types::victim_tag) ? way_tag[lru_idx] : addr_tag,
        addr_index,
        {cache_types::offset_bits{1'b0}}
    };

    // ------------------------------------------------------------
    // per-way storage
    // ------------------------------------------------------------

    logic                              fill_line;
    logic [cache_types::mask_bits-1:0] line_mask;
    logic [cache_types::line_bits-1:0] line_din;

    assign fill_line = (ctrl.data_src == cache_types::mem_data);
    assign line_mask = fill_line ? '1 : mem_byte_enable;
    assign line_din  = fill_line ? pmem_rdata : mem_wdata;

    for (genvar w = 0; w < cache_types::num_ways; w++) begin : g_way
        cache_data_array data_i (
            .clk   (clk),
            .we    (ctrl.ld_data && data_idx == 2'(w)),
            .wmask (line_mask),
            .index (addr_index),
            .din   (line_din),
            .dout  (way_data[w])
        );

        cache_tag_array tag_i (
            .clk   (clk),
            .we    (ctrl.ld_tag && lru_idx == 2'(w)),
            .index (addr_index),
            .din   (addr_tag),
            .dout  (way_tag[w])
        );

        cache_flag_array valid_i (
            .clk   (clk),
            .rst   (rst),
            .we    (ctrl.ld_valid && lru_idx == 2'(w)),
            .index (addr_index),
            .din   (1'b1),
            .dout  (way_valid[w])
        );

        cache_flag_array dirty_i (
            .clk   (clk),
            .rst   (rst),
            .we    (ctrl.ld_dirty && dirty_idx == 2'(w)),
            .index (addr_index),
            .din   (ctrl.dirty_val),
            .dout  (way_dirty[w])
        );
    end

    // ------------------------------------------------------------
    // tree pseudo-lru
    // ------------------------------------------------------------

    logic [2:0] plru [cache_types::num_sets];
    logic [2:0] plru_cur;
    logic [2:0] plru_next;

    assign plru_cur = plru[addr_index];

    // bit 0 picks the pair, bits 1 and 2 pick within it.
    always_comb begin
        if (plru_cur[0]) begin
            lru_idx = plru_cur[1] ? 2'd0 : 2'd1;
        end else begin
            lru_idx = plru_cur[2] ? 2'd2 : 2'd3;
        end
    end

    // the touched way follows the data write select, so a fill marks the filled way.
    always_comb begin
        case (data_idx)
            2'd0:    plru_next = {plru_cur[2], 1'b0, 1'b0};
            2'd1:    plru_next = {plru_cur[2], 1'b1, 1'b0};
            2'd2:    plru_next = {1'b0, plru_cur[1], 1'b1};
            default: plru_next = {1'b1, plru_cur[1], 1'b1};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < cache_types::num_sets; s++) begin
                plru[s] <= 3'b000;
            end
        end else if (ctrl.ld_plru) begin
            plru[addr_index] <= plru_next;
        end
    end

endmodule : cache_datapath

//--- cache_control.sv
`timescale 1ns/100ps

module cache_control (
    input  logic          clk,
    input  logic          rst,
    input  logic          mem_read,
    input  logic          mem_write,
    output logic          mem_resp,
    output logic          pmem_read,
    output logic          pmem_write,
    input  logic          pmem_resp,
    cache_ctrl_if.control ctrl
);

    cache_types::cache_state_t state;
    cache_types::cache_state_t next_state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_types::check;
        end else begin
            state <= next_state;
        end
    end

    // ------------------------------------------------------------
    // next state and outputs
    // ------------------------------------------------------------

    always_comb begin
        next_state = state;

        mem_resp   = 1'b0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;

        ctrl.ld_valid      = 1'b0;
        ctrl.ld_tag        = 1'b0;
        ctrl.ld_data       = 1'b0;
        ctrl.ld_dirty      = 1'b0;
        ctrl.ld_plru       = 1'b0;
        ctrl.dirty_val     = 1'b0;
        ctrl.data_way_sel  = cache_types::hit_way;
        ctrl.dirty_way_sel = cache_types::hit_way;
        ctrl.data_src      = cache_types::cpu_data;
        ctrl.pmem_addr_src = cache_types::cpu_tag;

        case (state)
            cache_types::check: begin
                if (mem_read || mem_write) begin
                    if (ctrl.hit) begin
                        // answered in the same cycle.
                        mem_resp     = 1'b1;
                        ctrl.ld_plru = 1'b1;
                        if (mem_write) begin
                            ctrl.ld_data   = 1'b1;
                            ctrl.ld_dirty  = 1'b1;
                            ctrl.dirty_val = 1'b1;
                        end
                    end else if (ctrl.victim_dirty) begin
                        next_state = cache_types::writeback;
                    end else begin
                        next_state = cache_types::fill;
                    end
                end
            end

            cache_types::writeback: begin
                pmem_write         = 1'b1;
                ctrl.pmem_addr_src = cache_types::victim_tag;
                if (pmem_resp) begin
                    next_state = cache_types::fill;
                end
            end

            cache_types::fill: begin
                pmem_read          = 1'b1;
                ctrl.data_way_sel  = cache_types::lru_way;
                ctrl.dirty_way_sel = cache_types::lru_way;
                ctrl.data_src      = cache_types::mem_data;
                if (pmem_resp) begin
                    // new line lands clean in the victim way.
                    ctrl.ld_data  = 1'b1;
                    ctrl.ld_tag   = 1'b1;
                    ctrl.ld_valid = 1'b1;
                    ctrl.ld_dirty = 1'b1;
                    ctrl.ld_plru  = 1'b1;
                    next_state    = cache_types::check;
                end
            end

            default: begin
                next_state = cache_types::check;
            end
        endcase
    end

endmodule : cache_control

//--- cache.sv
`timescale 1ns/100ps

module cache (
    input  logic                              clk,
    input  logic                              rst,

    // cpu side.
    input  logic [31:0]                       mem_address,
    input  logic                              mem_read,
    input  logic                              mem_write,
    input  logic [cache_types::mask_bits-1:0] mem_byte_enable,
    input  logic [cache_types::line_bits-1:0] mem_wdata,
    output logic [cache_types::line_bits-1:0] mem_rdata,
    output logic                              mem_resp,

    // physical memory side.
    output logic [31:0]                       pmem_address,
    output logic                              pmem_read,
    output logic                              pmem_write,
    output logic [cache_types::line_bits-1:0] pmem_wdata,
    input  logic [cache_types::line_bits-1:0] pmem_rdata,
    input  logic                              pmem_resp
);

    cache_ctrl_if ctrl_if ();

    cache_control control_i (
        .clk        (clk),
        .rst        (rst),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .pmem_resp  (pmem_resp),
        .ctrl       (ctrl_if.control)
    );

    cache_datapath datapath_i (
        .clk             (clk),
        .rst             (rst),
        .mem_address     (mem_address),
        .mem_byte_enable (mem_byte_enable),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .pmem_address    (pmem_address),
        .pmem_wdata      (pmem_wdata),
        .pmem_rdata      (pmem_rdata),
        .ctrl            (ctrl_if.datapath)
    );

endmodule : cache

//--- cache_chk.sv
`timescale 1ns/100ps

module cache_chk (
    input logic                              clk,
    input logic                              rst,
    input logic [31:0]                       mem_address,
    input logic                              mem_read,
    input logic                              mem_write,
    input logic [cache_types::mask_bits-1:0] mem_byte_enable,
    input logic [cache_types::line_bits-1:0] mem_wdata,
    input logic                              mem_resp,
    input logic [31:0]                       pmem_address,
    input logic                              pmem_read,
    input logic                              pmem_write,
    input logic                              pmem_resp
);

    logic [32+2+cache_types::mask_bits+cache_types::line_bits-1:0] cpu_req;

    assign cpu_req = {mem_address, mem_read, mem_write, mem_byte_enable, mem_wdata};

    pmem_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write))
        else $error("pmem_read and pmem_write high together");

    resp_with_request: assert property (@(posedge clk) disable iff (rst)
        mem_resp |-> (mem_read || mem_write))
        else $error("mem_resp without a cpu request");

    // address held until memory answers.
    pmem_address_held: assert property (@(posedge clk) disable iff (rst)
        (pmem_read || pmem_write) && !pmem_resp |=> $stable(pmem_address))
        else $error("pmem_address moved during a pending request");

    // a second pulse only belongs to a new request.
    single_resp: assert property (@(posedge clk) disable iff (rst)
        mem_resp |=> !mem_resp || !$stable(cpu_req))
        else $error("mem_resp held two cycles for one request");

endmodule : cache_chk

bind cache cache_chk chk_i (
    .clk             (clk),
    .rst             (rst),
    .mem_address     (mem_address),
    .mem_read        (mem_read),
    .mem_write       (mem_write),
    .mem_byte_enable (mem_byte_enable),
    .mem_wdata       (mem_wdata),
    .mem_resp        (mem_resp),
    .pmem_address    (pmem_address),
    .pmem_read       (pmem_read),
    .pmem_write      (pmem_write),
    .pmem_resp       (pmem_resp)
);

//--- cache_tb.sv
`timescale 1ns/100ps

module cache_tb;

    localparam int num_requests = 400;
    localparam int num_tags     = 6;
    localparam int num_lines    = num_tags * cache_types::num_sets;
    localparam int clk_period   = 40;

    logic                              clk;
    logic                              rst;
    logic [31:0]                       mem_address;
    logic                              mem_read;
    logic                              mem_write;
    logic [cache_types::mask_bits-1:0] mem_byte_enable;
    logic [cache_types::line_bits-1:0] mem_wdata;
    logic [cache_types::line_bits-1:0] mem_rdata;
    logic                              mem_resp;
    logic [31:0]                       pmem_address;
    logic                              pmem_read;
    logic                              pmem_write;
    logic [cache_types::line_bits-1:0] pmem_wdata;
    logic [cache_types::line_bits-1:0] pmem_rdata = '0;
    logic                              pmem_resp = 1'b0;

    cache dut_i (
        .clk             (clk),
        .rst             (rst),
        .mem_address     (mem_address),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .mem_resp        (mem_resp),
        .pmem_address    (pmem_address),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .pmem_wdata      (pmem_wdata),
        .pmem_rdata      (pmem_rdata),
        .pmem_resp       (pmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(num_requests * 30 * clk_period);
        $display("timeout: requests still pending after %0d cycles", num_requests * 30);
        $display("TEST FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    // random numbers and address mapping
    // ------------------------------------------------------------

    logic [31:0] lfsr;

    // fibonacci, taps 32 22 2 1.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [255:0] rand_line();
        logic [255:0] v;
        for (int i = 0; i < 8; i++) begin
            v[32*i +: 32] = rand_bits(32);
        end
        return v;
    endfunction

    function automatic logic [22:0] tag_of(input int t);
        return 23'(t * 951 + 20896);
    endfunction

    // line number is tag slot times sets plus set.
    function automatic logic [31:0] addr_of(input int line);
        logic [3:0] set;
        set = 4'(line % cache_types::num_sets);
        return {tag_of(line / cache_types::num_sets), set, 5'b00000};
    endfunction

    function automatic int line_of(input logic [31:0] addr);
        int line;
        line = -1;
        for (int t = 0; t < num_tags; t++) begin
            if (addr[31:9] == tag_of(t) && addr[4:0] == 5'd0) begin
                line = t * cache_types::num_sets + int'(addr[8:5]);
            end
        end
        return line;
    endfunction

    function automatic logic [255:0] merge(input logic [255:0] old_line,
                                           input logic [255:0] new_line,
                                           input logic [31:0]  be);
        logic [255:0] m;
        for (int b = 0; b < 32; b++) begin
            m[8*b +: 8] = {8{be[b]}};
        end
        return (old_line & ~m) | (new_line & m);
    endfunction

    // ------------------------------------------------------------
    // shadow cache model
    // ------------------------------------------------------------

    int         sh_tag   [cache_types::num_sets][cache_types::num_ways];
    logic       sh_valid [cache_types::num_sets][cache_types::num_ways];
    logic       sh_dirty [cache_types::num_sets][cache_types::num_ways];
    logic [2:0] sh_plru  [cache_types::num_sets];
    int         exp_n;
    int         exp_kind [2];
    int         exp_line [2];

    function automatic int lru_of(input logic [2:0] p);
        if (p[0]) begin
            return p[1] ? 0 : 1;
        end
        return p[2] ? 2 : 3;
    endfunction

    function automatic logic [2:0] touch(input logic [2:0] p, input int way);
        logic [2:0] n;
        n = p;
        case (way)
            0: begin
                n[1] = 1'b0;
                n[0] = 1'b0;
            end
            1: begin
                n[1] = 1'b1;
                n[0] = 1'b0;
            end
            2: begin
                n[2] = 1'b0;
                n[0] = 1'b1;
            end
            default: begin
                n[2] = 1'b1;
                n[0] = 1'b1;
            end
        endcase
        return n;
    endfunction

    // kind 1 is a write-back, kind 0 a fill.
    task automatic predict(input int t, input int s, input logic is_write);
        int way;
        int v;
        way   = -1;
        exp_n = 0;
        for (int w = 0; w < cache_types::num_ways; w++) begin
            if (sh_valid[s][w] && sh_tag[s][w] == t) begin
                way = w;
            end
        end
        if (way < 0) begin
            v = lru_of(sh_plru[s]);
            if (sh_valid[s][v] && sh_dirty[s][v]) begin
                exp_kind[0] = 1;
                exp_line[0] = sh_tag[s][v] * cache_types::num_sets + s;
                exp_n       = 1;
            end
            exp_kind[exp_n] = 0;
            exp_line[exp_n] = t * cache_types::num_sets + s;
            exp_n++;
            sh_tag[s][v]   = t;
            sh_valid[s][v] = 1'b1;
            sh_dirty[s][v] = 1'b0;
            sh_plru[s]     = touch(sh_plru[s], v);
            way            = v;
        end
        sh_plru[s] = touch(sh_plru[s], way);
        if (is_write) begin
            sh_dirty[s][way] = 1'b1;
        end
    endtask

    // ------------------------------------------------------------
    // physical memory model
    // ------------------------------------------------------------

    logic [255:0] ref_mem [num_lines];
    logic [255:0] backing [num_lines];
    int           ev_kind [1024];
    int           ev_line [1024];
    int           ev_count = 0;
    int           lat_wb = 0;
    int           lat_fill = 0;
    int           mem_wait = 0;
    logic         mem_busy = 1'b0;
    int           err_mem = 0;

    always @(posedge clk) begin
        int line;
        if (rst) begin
            pmem_resp <= 1'b0;
            mem_busy = 1'b0;
            for (int i = 0; i < num_lines; i++) begin
                backing[i] = ref_mem[i];
            end
        end else if (pmem_resp) begin
            pmem_resp <= 1'b0;
            mem_busy = 1'b0;
        end else if (pmem_read || pmem_write) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_wait = pmem_write ? lat_wb : lat_fill;
            end
            if (mem_wait == 0) begin
                line = line_of(pmem_address);
                if (line < 0) begin
                    err_mem++;
                    $display("FAILED %0t: pmem address %h outside the test lines",
                             $time, pmem_address);
                end else if (pmem_write) begin
                    ev_kind[ev_count] = 1;
                    ev_line[ev_count] = line;
                    ev_count++;
                    if (pmem_wdata !== ref_mem[line]) begin
                        err_mem++;
                        $display("FAILED %0t: write-back data wrong for line %0d", $time, line);
                    end
                    backing[line] = pmem_wdata;
                end else begin
                    ev_kind[ev_count] = 0;
                    ev_line[ev_count] = line;
                    ev_count++;
                    pmem_rdata <= backing[line];
                end
                pmem_resp <= 1'b1;
            end else begin
                mem_wait--;
            end
        end
    end

    // ------------------------------------------------------------
    // stimulus and checks
    // ------------------------------------------------------------

    int err_data = 0;
    int err_seq = 0;
    int err_rst = 0;

    task automatic check_idle(input string when_txt);
        if (mem_resp !== 1'b0 || pmem_read !== 1'b0 || pmem_write !== 1'b0) begin
            err_rst++;
            $display("FAILED %0t: outputs not idle %s", $time, when_txt);
        end
    endtask

    initial begin
        int           t;
        int           s;
        int           line;
        int           idle;
        int           first_ev;
        logic         is_write;
        logic [31:0]  be;
        logic [255:0] wdata;

        lfsr            = 32'h16dc;
        rst             = 1'b1;
        mem_address     = '0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_byte_enable = '0;
        mem_wdata       = '0;
        for (int i = 0; i < num_lines; i++) begin
            ref_mem[i] = rand_line();
        end
        for (int i = 0; i < cache_types::num_sets; i++) begin
            sh_plru[i] = 3'b000;
            for (int w = 0; w < cache_types::num_ways; w++) begin
                sh_tag[i][w]   = -1;
                sh_valid[i][w] = 1'b0;
                sh_dirty[i][w] = 1'b0;
            end
        end

        repeat (2) begin
            @(negedge clk);
            check_idle("during reset");
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_idle("after reset");

        for (int n = 0; n < num_requests; n++) begin
            t        = int'(rand_bits(3)) % num_tags;
            s        = int'(rand_bits(4));
            line     = t * cache_types::num_sets + s;
            is_write = (rand_bits(1) != 32'd0);
            be       = rand_bits(32);
            // fresh data each request, reads included.
            wdata    = rand_line();
            idle     = int'(rand_bits(2));
            lat_wb   = int'(rand_bits(2));
            lat_fill = int'(rand_bits(2));
            predict(t, s, is_write);

            repeat (idle) begin
                @(posedge clk);
                mem_read  <= 1'b0;
                mem_write <= 1'b0;
            end
            @(posedge clk);
            first_ev = ev_count;
            mem_address     <= addr_of(line);
            mem_read        <= !is_write;
            mem_write       <= is_write;
            mem_byte_enable <= be;
            mem_wdata       <= wdata;

            @(negedge clk);
            while (mem_resp !== 1'b1) begin
                @(negedge clk);
            end

            if (ev_count - first_ev != exp_n) begin
                err_seq++;
                $display("FAILED %0t: request %0d expected %0d memory accesses, saw %0d",
                         $time, n, exp_n, ev_count - first_ev);
            end else begin
                for (int i = 0; i < exp_n; i++) begin
                    if (ev_kind[first_ev + i] != exp_kind[i] ||
                        ev_line[first_ev + i] != exp_line[i]) begin
                        err_seq++;
                        $display("FAILED %0t: request %0d access %0d wrong kind or line %0d",
                                 $time, n, i, ev_line[first_ev + i]);
                    end
                end
            end

            if (is_write) begin
                ref_mem[line] = merge(ref_mem[line], wdata, be);
            end else if (mem_rdata !== ref_mem[line]) begin
                err_data++;
                $display("FAILED %0t: read data wrong for line %0d", $time, line);
            end
        end

        @(posedge clk);
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        repeat (2) @(posedge clk);

        $display("errors: data %0d, sequence %0d, reset %0d, memory %0d",
                 err_data, err_seq, err_rst, err_mem);
        if (err_data + err_seq + err_rst + err_mem == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : cache_tb

//--- cache.f
cache_types.sv
cache_ctrl_if.sv
cache_data_array.sv
cache_tag_array.sv
cache_flag_array.sv
cache_datapath.sv
cache_control.sv
cache.sv
cache_chk.sv
cache_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cache_tb -f cache.f -o cache_sim

out=$(./obj_dir/cache_sim)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
else
    exit 1
fi
